// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fmc_apb_bridge
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= list.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/apb_completer_model.sv ====
`timescale 1ns/1ps

module apb_completer_model (
	input  logic                   apb,
	input  logic                   psel,
	input  logic                   penable,
	input  fmc_apb_pkg::apb_addr_t paddr,
	input  logic                   pwrite,
	input  fmc_apb_pkg::apb_data_t pwdata,
	input  fmc_apb_pkg::apb_strb_t pstrb,
	output logic                   pready,
	output fmc_apb_pkg::apb_data_t prdata,
	// Transfer log, completions so far and protocol trouble
	output int unsigned            rd_done,
	output int unsigned            wr_done,
	output logic                   overlap_err
);

	integer seed = 32'h62e3_c949;

	// Sparse memory, one entry per APB address written
	fmc_apb_pkg::apb_data_t mem [fmc_apb_pkg::apb_addr_t];

	logic open;
	int stall;
	fmc_apb_pkg::apb_addr_t cur_addr;
	logic cur_write;

	// Unwritten words read back a pattern built from the whole address
	function automatic fmc_apb_pkg::apb_data_t word_at(input fmc_apb_pkg::apb_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {5'd0, a} ^ 32'hc3a5_96e1;
	endfunction

	initial begin
		pready = 1'b0;
		prdata = '0;
		rd_done = 0;
		wr_done = 0;
		overlap_err = 1'b0;
		open = 1'b0;
		stall = 0;
	end

	always @(posedge apb) begin
		if (open) begin
			// Anything new on the bus before pready means a second transfer began
			if (!psel || !penable || paddr !== cur_addr || pwrite !== cur_write)
				overlap_err <= 1'b1;
			if (pready) begin
				if (cur_write) begin
					for (int b = 0; b < 4; b++)
						if (pstrb[b])
							mem[cur_addr][8*b +: 8] = pwdata[8*b +: 8];
					wr_done <= wr_done + 1;
				end else begin
					rd_done <= rd_done + 1;
				end
				open <= 1'b0;
				pready <= 1'b0;
			end else if (stall <= 1) begin
				pready <= 1'b1;
				prdata <= word_at(paddr);
			end else begin
				stall = stall - 1;
			end
		end else if (psel && penable) begin
			open <= 1'b1;
			cur_addr <= paddr;
			cur_write <= pwrite;
			// 0 to 3 stall clocks
			stall = int'($unsigned($random(seed)) % 4);
			if (stall == 0) begin
				pready <= 1'b1;
				prdata <= word_at(paddr);
			end
		end else if (psel) begin
			// Select without enable never happens on this requester
			overlap_err <= 1'b1;
		end
	end

endmodule

// ==== bench/tb_fmc_apb_bridge.sv ====
`timescale 1ns/1ps
`include "fmc_apb_defines.svh"

module tb_fmc_apb_bridge;

	localparam int N_BURST = 60;
	localparam int N_POOL = 8;

	logic apb = 1'b0;
	logic pll_lock, cs_n, nadv, nwe, noe, pready;
	logic [1:0] nbl;
	logic [`FMC_AHI_W-1:0] a_hi;
	fmc_apb_pkg::fmc_half_t ad_in, ad_out;
	logic ad_oe, nwait, psel, penable, pwrite, overlap_err;
	fmc_apb_pkg::apb_addr_t paddr;
	fmc_apb_pkg::apb_data_t pwdata, prdata;
	fmc_apb_pkg::apb_strb_t pstrb;
	fmc_apb_pkg::xfer_cnt_t reads_per_window, writes_per_window;
	int unsigned rd_done, wr_done;

	integer seed = 32'h62e3_c949;

	// Reference memory and the APB transfers still expected, in order
	fmc_apb_pkg::apb_data_t ref_mem [fmc_apb_pkg::apb_addr_t];
	logic exp_write_q [$];
	fmc_apb_pkg::apb_addr_t exp_addr_q [$];
	fmc_apb_pkg::apb_data_t exp_data_q [$];
	fmc_apb_pkg::apb_strb_t exp_strb_q [$];

	logic [`FMC_AHI_W-1:0] pool_ahi [N_POOL];
	fmc_apb_pkg::fmc_half_t pool_ad [N_POOL];

	int edge_n = 0;
	int snap_checks = 0;
	int n_writes = 0;
	int unsigned base_rd = 0;
	int unsigned base_wr = 0;
	logic lock_dropped = 1'b0;

	always #5 apb = ~apb;

	fmc_apb_bridge DUT (.apb, .pll_lock, .cs_n, .nadv, .nwe, .noe, .nbl, .a_hi, .ad_in,
		.ad_out, .ad_oe, .nwait, .psel, .penable, .paddr, .pwrite, .pwdata, .pstrb, .pready,
		.prdata, .reads_per_window, .writes_per_window);

	apb_completer_model u_mem (.apb, .psel, .penable, .paddr, .pwrite, .pwdata, .pstrb,
		.pready, .prdata, .rd_done, .wr_done, .overlap_err);

	//////////////////////////////
	// Reporting

	task automatic stop_on_error(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input fmc_apb_pkg::apb_data_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_addr(input fmc_apb_pkg::apb_addr_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_count(input fmc_apb_pkg::xfer_cnt_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_strb(input fmc_apb_pkg::apb_strb_t got, exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	//////////////////////////////
	// Host model

	// Block until an edge where a beat moves in the given state
	task automatic wait_beat(input fmc_apb_pkg::fmc_state_t st);
		do
			@(negedge apb);
		while (!(nwait && DUT.u_frontend.state == st));
	endtask

	task automatic addr_phase(input int p, input logic wr);
		@(posedge apb);
		cs_n <= 1'b0;
		nadv <= 1'b0;
		nwe <= !wr;
		a_hi <= pool_ahi[p];
		ad_in <= pool_ad[p];
	endtask

	task automatic host_write(input int p, input fmc_apb_pkg::apb_data_t d,
		input logic [1:0] nbl_lo, nbl_hi);
		fmc_apb_pkg::apb_addr_t a;
		fmc_apb_pkg::apb_strb_t s;
		a = {pool_ahi[p], pool_ad[p], 1'b0};
		s = {~nbl_hi, ~nbl_lo};
		// Byte-lane merge into the reference word
		if (!ref_mem.exists(a))
			ref_mem[a] = '0;
		for (int b = 0; b < 4; b++)
			if (s[b])
				ref_mem[a][8*b +: 8] = d[8*b +: 8];
		exp_write_q.push_back(1'b1);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
		exp_strb_q.push_back(s);
		n_writes++;
		addr_phase(p, 1'b1);
		@(posedge apb);
		nadv <= 1'b1;
		ad_in <= d[15:0];
		nbl <= nbl_lo;
		wait_beat(fmc_apb_pkg::WDATA_LO);
		@(posedge apb);
		ad_in <= d[31:16];
		nbl <= nbl_hi;
		wait_beat(fmc_apb_pkg::WDATA_HI);
		@(posedge apb);
		cs_n <= 1'b1;
		nwe <= 1'b1;
		nbl <= 2'b11;
	endtask

	task automatic host_read(input int p);
		fmc_apb_pkg::apb_addr_t a;
		fmc_apb_pkg::fmc_half_t lo;
		fmc_apb_pkg::fmc_half_t hi;
		a = {pool_ahi[p], pool_ad[p], 1'b0};
		exp_write_q.push_back(1'b0);
		exp_addr_q.push_back(a);
		exp_data_q.push_back('0);
		exp_strb_q.push_back('0);
		addr_phase(p, 1'b0);
		@(posedge apb);
		nadv <= 1'b1;
		noe <= 1'b0;
		wait_beat(fmc_apb_pkg::RDATA_LO);
		lo = ad_out;
		if (ad_oe !== 1'b1)
			stop_on_error("ad_oe low during a read beat");
		@(posedge apb);
		wait_beat(fmc_apb_pkg::RDATA_HI);
		hi = ad_out;
		@(posedge apb);
		cs_n <= 1'b1;
		noe <= 1'b1;
		check_data({hi, lo}, ref_mem[a], "read beats");
	endtask

	//////////////////////////////
	// APB and status monitor

	// Clocks since lock came up, Pk gives k
	always @(posedge apb)
		if (pll_lock)
			edge_n = edge_n + 1;

	always @(negedge apb) begin
		if (!lock_dropped) begin
			// Reset release exactly at the stretch length
			if (DUT.bridge_rst_n !== (edge_n >= `RST_STRETCH + 1))
				stop_on_error("bridge reset released at the wrong clock");
			if (edge_n < `RST_STRETCH + 1
				&& (nwait !== 1'b1 || ad_oe !== 1'b0 || psel !== 1'b0 || penable !== 1'b0))
				stop_on_error("host or APB side active during reset");
			if (overlap_err)
				stop_on_error("APB transfer started while another was open");
			// Window end just passed, snapshot holds that window's completions
			if (edge_n >= `RST_STRETCH + 1 + `XFER_WINDOW
				&& (edge_n - `RST_STRETCH - 1) % `XFER_WINDOW == 0) begin
				check_count(reads_per_window, 16'(rd_done - base_rd), "reads_per_window");
				check_count(writes_per_window, 16'(wr_done - base_wr), "writes_per_window");
				base_rd = rd_done;
				base_wr = wr_done;
				snap_checks++;
			end
			// Transfer completes on the coming edge
			if (psel && penable && pready) begin
				if (exp_addr_q.size() == 0)
					stop_on_error("APB transfer with no host burst behind it");
				if (pwrite !== exp_write_q[0])
					stop_on_error("APB transfer in the wrong direction");
				check_addr(paddr, exp_addr_q[0], "paddr");
				if (pwrite) begin
					check_data(pwdata, exp_data_q[0], "pwdata");
					check_strb(pstrb, exp_strb_q[0], "pstrb");
				end
				void'(exp_write_q.pop_front());
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_strb_q.pop_front());
			end
		end
	end

	// Watchdog sized from the burst count plus the reset and window tail
	initial begin
		#((200 * N_BURST + 2 * `RST_STRETCH + 2 * `XFER_WINDOW + 32) * 10);
		$display("Simulation timed out before all bursts finished");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////
	// Main sequence

	initial begin
		int r;
		int prev;
		pll_lock = 1'b0;
		cs_n = 1'b1;
		nadv = 1'b1;
		nwe = 1'b1;
		noe = 1'b1;
		nbl = 2'b11;
		a_hi = '0;
		ad_in = '0;
		for (int i = 0; i < N_POOL; i++) begin
			r = $random(seed);
			pool_ahi[i] = r[25:16];
			pool_ad[i] = r[15:0];
		end
		repeat (16) @(posedge apb);
		pll_lock <= 1'b1;
		wait (edge_n >= `RST_STRETCH + 2);

		// Full-word writes first so every read has a known word
		for (int i = 0; i < N_POOL; i++)
			host_write(i, $random(seed), 2'b00, 2'b00);
		// Random mix back to back
		for (int i = N_POOL; i < N_BURST; i++) begin
			r = $random(seed);
			if (r[31])
				host_read(int'(r[6:4]));
			else
				host_write(int'(r[6:4]), $random(seed), r[1:0], r[3:2]);
		end

		while (exp_addr_q.size() != 0)
			@(posedge apb);
		prev = snap_checks;
		wait (snap_checks > prev);
		check_count(16'(wr_done), 16'(n_writes), "APB writes in total");

		// Loss of lock puts the bridge back into reset at once
		@(posedge apb);
		lock_dropped = 1'b1;
		pll_lock <= 1'b0;
		#1;
		if (DUT.bridge_rst_n !== 1'b0 || nwait !== 1'b1 || psel !== 1'b0 || penable !== 1'b0)
			stop_on_error("bridge not back in reset after lock loss");
		check_count(reads_per_window, '0, "reads_per_window in reset");
		check_count(writes_per_window, '0, "writes_per_window in reset");

		if (snap_checks == 0) begin
			$display("No counter window was checked");
			$display("CHECKS FAILED");
			$fatal(1, "counter window never reached");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== hdl/apb_requester.sv ====
`timescale 1ns/1ps

module apb_requester (
	input  logic                   apb,
	input  logic                   bridge_rst_n,
	// Request from the host side
	input  logic                   req_valid,
	input  fmc_apb_pkg::apb_addr_t req_addr,
	input  logic                   req_write,
	input  fmc_apb_pkg::apb_data_t req_wdata,
	input  fmc_apb_pkg::apb_strb_t req_strb,
	// APB
	output logic                   psel,
	output logic                   penable,
	output fmc_apb_pkg::apb_addr_t paddr,
	output logic                   pwrite,
	output fmc_apb_pkg::apb_data_t pwdata,
	output fmc_apb_pkg::apb_strb_t pstrb,
	input  logic                   pready,
	input  fmc_apb_pkg::apb_data_t prdata,
	// Status back to the frontend and counters
	output logic                   busy,
	output fmc_apb_pkg::apb_data_t rdata,
	output logic                   done_read,
	output logic                   done_write
);

	logic xfer_end;

	// Completion is the access phase meeting pready
	assign xfer_end = penable && pready;
	assign done_read = xfer_end && !pwrite;
	assign done_write = xfer_end && pwrite;
	assign busy = psel;

	// Select and enable rise together, one transfer at a time
	always_ff @(posedge apb or negedge bridge_rst_n) begin
		if (!bridge_rst_n) begin
			psel <= 1'b0;
			penable <= 1'b0;
		end else if (req_valid) begin
			psel <= 1'b1;
			penable <= 1'b1;
		end else if (xfer_end) begin
			psel <= 1'b0;
			penable <= 1'b0;
		end
	end

	always_ff @(posedge apb) begin
		if (req_valid) begin
			paddr <= req_addr;
			pwrite <= req_write;
			pwdata <= req_wdata;
			pstrb <= req_strb;
		end
		// Keep read data for the host's two beats
		if (done_read)
			rdata <= prdata;
	end

	//////////////////////////////
	// Checks

	// Frontend never issues into an open transfer
	assert property (@(posedge apb) disable iff (!bridge_rst_n) req_valid |-> !psel)
		else $error("request overlaps an open APB transfer");

	// Address held through back-pressure
	assert property (@(posedge apb) disable iff (!bridge_rst_n)
		penable && !pready |=> $stable(paddr))
		else $error("paddr changed during a stalled transfer");

endmodule

// ==== hdl/fmc_apb_bridge.sv ====
`timescale 1ns/1ps
`include "fmc_apb_defines.svh"

module fmc_apb_bridge (
	input  logic                   apb,
	input  logic                   pll_lock,
	// Host bus
	input  logic                   cs_n,
	input  logic                   nadv,
	input  logic                   nwe,
	input  logic                   noe,
	input  logic [1:0]             nbl,
	input  logic [`FMC_AHI_W-1:0]  a_hi,
	input  fmc_apb_pkg::fmc_half_t ad_in,
	output fmc_apb_pkg::fmc_half_t ad_out,
	output logic                   ad_oe,
	output logic                   nwait,
	// APB
	output logic                   psel,
	output logic                   penable,
	output fmc_apb_pkg::apb_addr_t paddr,
	output logic                   pwrite,
	output fmc_apb_pkg::apb_data_t pwdata,
	output fmc_apb_pkg::apb_strb_t pstrb,
	input  logic                   pready,
	input  fmc_apb_pkg::apb_data_t prdata,
	// Throughput per window
	output fmc_apb_pkg::xfer_cnt_t reads_per_window,
	output fmc_apb_pkg::xfer_cnt_t writes_per_window
);

	logic bridge_rst_n;

	// Frontend to requester
	logic req_valid;
	fmc_apb_pkg::apb_addr_t req_addr;
	logic req_write;
	fmc_apb_pkg::apb_data_t req_wdata;
	fmc_apb_pkg::apb_strb_t req_strb;

	// Requester status
	logic busy;
	fmc_apb_pkg::apb_data_t rdata;
	logic done_read;
	logic done_write;

	// Host drives the pins whenever noe is high
	assign ad_oe = ~noe;

	reset_stretch u_reset (.apb, .pll_lock, .bridge_rst_n);

	fmc_frontend u_frontend (.apb, .bridge_rst_n, .cs_n, .nadv, .nwe, .nbl, .a_hi, .ad_in,
		.ad_out, .nwait, .busy, .rdata, .req_valid, .req_addr, .req_write, .req_wdata, .req_strb);

	apb_requester u_requester (.apb, .bridge_rst_n, .req_valid, .req_addr, .req_write,
		.req_wdata, .req_strb, .psel, .penable, .paddr, .pwrite, .pwdata, .pstrb, .pready,
		.prdata, .busy, .rdata, .done_read, .done_write);

	xfer_counters u_counters (.apb, .bridge_rst_n, .done_read, .done_write,
		.reads_per_window, .writes_per_window);

endmodule

// ==== hdl/fmc_apb_defines.svh ====
`ifndef FMC_APB_DEFINES_SVH
`define FMC_APB_DEFINES_SVH

//////////////////////////////
// Bus widths

// Multiplexed address/data pins on the host side
`define FMC_AD_W 16
// High address pins, above the AD bus
`define FMC_AHI_W 10
// Byte address, high pins + AD word address + implicit zero LSB
`define APB_ADDR_W 27
`define APB_DATA_W 32

//////////////////////////////
// Timing

// Clocks of reset held after the PLL reports lock
`define RST_STRETCH 15
// Host reaction time to a write wait state, in clocks
`define WAIT_RTT 1
// Counter window in clocks, kept short for simulation
`define XFER_WINDOW 256
`define XFER_CNT_W 16

`endif

// ==== hdl/fmc_apb_pkg.sv ====
`include "fmc_apb_defines.svh"

package fmc_apb_pkg;

	// Byte address on APB
	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`APB_DATA_W-1:0] apb_data_t;
	// One beat on the AD pins
	typedef logic [`FMC_AD_W-1:0] fmc_half_t;
	// One strobe bit per APB byte lane
	typedef logic [`APB_DATA_W/8-1:0] apb_strb_t;
	typedef logic [`XFER_CNT_W-1:0] xfer_cnt_t;

	// Host burst sequencing
	typedef enum logic [3:0] {
		ADDR,
		WAIT,
		WAIT2,
		WDATA_LO,
		WDATA_WAIT,
		WDATA_HI,
		ACTIVE,
		RDATA_LO,
		RDATA_HI,
		RD_END
	} fmc_state_t;

endpackage

// ==== hdl/fmc_frontend.sv ====
`timescale 1ns/1ps
`include "fmc_apb_defines.svh"

module fmc_frontend (
	input  logic                   apb,
	input  logic                   bridge_rst_n,
	// Host pins
	input  logic                   cs_n,
	input  logic                   nadv,
	input  logic                   nwe,
	input  logic [1:0]             nbl,
	input  logic [`FMC_AHI_W-1:0]  a_hi,
	input  fmc_apb_pkg::fmc_half_t ad_in,
	output fmc_apb_pkg::fmc_half_t ad_out,
	output logic                   nwait,
	// Requester side
	input  logic                   busy,
	input  fmc_apb_pkg::apb_data_t rdata,
	output logic                   req_valid,
	output fmc_apb_pkg::apb_addr_t req_addr,
	output logic                   req_write,
	output fmc_apb_pkg::apb_data_t req_wdata,
	output fmc_apb_pkg::apb_strb_t req_strb
);

	localparam int unsigned WCNT_W = $clog2(`WAIT_RTT + 2);

	fmc_apb_pkg::fmc_state_t state;

	// Address phase results
	fmc_apb_pkg::apb_addr_t pend_addr;
	logic pend_write;

	// Busy seen one clock late, lines up with what the host saw on nwait
	logic busy_ff;
	logic [WCNT_W-1:0] wait_cnt;

	// First write beat, held until the high beat arrives
	fmc_apb_pkg::fmc_half_t wdata_lo;
	logic [1:0] strb_lo;

	logic beat;
	logic rd_dispatch;
	logic wr_dispatch;

	//////////////////////////////
	// Request outputs

	// Edge where the host moves a beat, if the state is a data state
	assign beat = !cs_n && nwait;

	// Reads go out as soon as the APB side is free
	assign rd_dispatch = !cs_n && state == fmc_apb_pkg::WAIT && !pend_write && !busy;
	// Writes go out with the high beat straight from the pins
	assign wr_dispatch = beat && state == fmc_apb_pkg::WDATA_HI;

	assign req_valid = rd_dispatch || wr_dispatch;
	assign req_addr = pend_addr;
	assign req_write = pend_write;
	assign req_wdata = {ad_in, wdata_lo};
	// nbl is active low, strobes are active high
	assign req_strb = {~nbl, strb_lo};

	// Read beats, low half first
	always_comb begin
		case (state)
			fmc_apb_pkg::RDATA_LO: ad_out = rdata[`FMC_AD_W-1:0];
			fmc_apb_pkg::RDATA_HI: ad_out = rdata[`APB_DATA_W-1:`FMC_AD_W];
			default:               ad_out = '0;
		endcase
	end

	//////////////////////////////
	// Wait generation

	// Stall while APB is busy or while a read is being handed over
	always_ff @(posedge apb or negedge bridge_rst_n) begin
		if (!bridge_rst_n) begin
			nwait <= 1'b1;
			busy_ff <= 1'b0;
		end else begin
			busy_ff <= busy;
			nwait <= !(!cs_n && (busy || (state == fmc_apb_pkg::WAIT && !pend_write)));
		end
	end

	//////////////////////////////
	// Burst FSM

	always_ff @(posedge apb or negedge bridge_rst_n) begin
		if (!bridge_rst_n) begin
			state <= fmc_apb_pkg::ADDR;
			pend_write <= 1'b0;
			wait_cnt <= '0;
		end else if (cs_n) begin
			// Deselect ends any burst
			state <= fmc_apb_pkg::ADDR;
		end else begin
			case (state)
				fmc_apb_pkg::ADDR: begin
					if (!nadv) begin
						state <= fmc_apb_pkg::WAIT;
						pend_write <= !nwe;
					end
				end
				fmc_apb_pkg::WAIT: begin
					if (pend_write)
						state <= fmc_apb_pkg::WAIT2;
					else if (!busy)
						state <= fmc_apb_pkg::RDATA_LO;
				end
				// Previous write has to drain before new data is taken
				fmc_apb_pkg::WAIT2: begin
					if (!busy_ff)
						state <= fmc_apb_pkg::WDATA_LO;
				end
				fmc_apb_pkg::WDATA_LO: begin
					if (nwait) begin
						if (busy_ff) begin
							state <= fmc_apb_pkg::WDATA_WAIT;
							wait_cnt <= '0;
						end else begin
							state <= fmc_apb_pkg::WDATA_HI;
						end
					end
				end
				// Give the host time to see nwait go high again
				fmc_apb_pkg::WDATA_WAIT: begin
					if (!busy_ff) begin
						wait_cnt <= wait_cnt + 1'b1;
						if (wait_cnt >= WCNT_W'(`WAIT_RTT))
							state <= fmc_apb_pkg::WDATA_HI;
					end
				end
				fmc_apb_pkg::WDATA_HI: begin
					if (nwait)
						state <= fmc_apb_pkg::ACTIVE;
				end
				fmc_apb_pkg::RDATA_LO: begin
					if (nwait)
						state <= fmc_apb_pkg::RDATA_HI;
				end
				fmc_apb_pkg::RDATA_HI: begin
					if (nwait)
						state <= fmc_apb_pkg::RD_END;
				end
				// ACTIVE and RD_END sit until chip select drops
				default: state <= state;
			endcase
		end
	end

	// Address and low write beat
	always_ff @(posedge apb) begin
		// Word address, LSB is always zero on a 16-bit bus
		if (!cs_n && !nadv && state == fmc_apb_pkg::ADDR)
			pend_addr <= {a_hi, ad_in, 1'b0};
		if (beat && state == fmc_apb_pkg::WDATA_LO) begin
			wdata_lo <= ad_in;
			strb_lo <= ~nbl;
		end
	end

	//////////////////////////////
	// Checks

	// The WAIT2 gate must keep writes away from a busy requester
	assert property (@(posedge apb) disable iff (!bridge_rst_n) req_valid |-> !busy)
		else $error("request raised while APB side busy");

endmodule

// ==== hdl/reset_stretch.sv ====
`timescale 1ns/1ps
`include "fmc_apb_defines.svh"

module reset_stretch (
	input  logic apb,
	input  logic pll_lock,
	output logic bridge_rst_n
);

	// Clocks seen since lock came up
	logic [3:0] lock_cnt;

	// Lock loss clears everything at once
	// Release happens on the clock after the count reaches the stretch length
	always_ff @(posedge apb or negedge pll_lock) begin
		if (!pll_lock) begin
			lock_cnt <= 4'd0;
			bridge_rst_n <= 1'b0;
		end else if (!bridge_rst_n) begin
			if (lock_cnt == 4'(`RST_STRETCH))
				bridge_rst_n <= 1'b1;
			else
				lock_cnt <= lock_cnt + 4'd1;
		end
	end

	//////////////////////////////
	// Checks

	// Reset stays low while lock is low and for the whole stretch after it
	assert property (@(posedge apb)
		(!pll_lock || !$past(pll_lock, `RST_STRETCH + 1)) |-> !bridge_rst_n)
		else $error("bridge reset released without a full stretch after lock");

endmodule

// ==== hdl/xfer_counters.sv ====
`timescale 1ns/1ps
`include "fmc_apb_defines.svh"

module xfer_counters (
	input  logic                   apb,
	input  logic                   bridge_rst_n,
	input  logic                   done_read,
	input  logic                   done_write,
	output fmc_apb_pkg::xfer_cnt_t reads_per_window,
	output fmc_apb_pkg::xfer_cnt_t writes_per_window
);

	localparam int unsigned WIN_W = $clog2(`XFER_WINDOW);

	logic [WIN_W-1:0] win_cnt;
	logic win_end;

	// Index 0 counts reads, index 1 writes
	logic [1:0] done;
	fmc_apb_pkg::xfer_cnt_t run [2];
	fmc_apb_pkg::xfer_cnt_t snap [2];

	assign done = {done_write, done_read};
	assign win_end = win_cnt == WIN_W'(`XFER_WINDOW - 1);

	// Free-running window, first one starts at reset release
	always_ff @(posedge apb or negedge bridge_rst_n) begin
		if (!bridge_rst_n)
			win_cnt <= '0;
		else if (win_end)
			win_cnt <= '0;
		else
			win_cnt <= win_cnt + 1'b1;
	end

	// Snapshot takes the completion on the window's last clock as well
	always_ff @(posedge apb or negedge bridge_rst_n) begin
		if (!bridge_rst_n) begin
			for (int i = 0; i < 2; i++) begin
				run[i] <= '0;
				snap[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (win_end) begin
					snap[i] <= run[i] + fmc_apb_pkg::xfer_cnt_t'(done[i]);
					run[i] <= '0;
				end else begin
					run[i] <= run[i] + fmc_apb_pkg::xfer_cnt_t'(done[i]);
				end
			end
		end
	end

	assign reads_per_window = snap[0];
	assign writes_per_window = snap[1];

endmodule

// ==== list.f ====
+incdir+hdl
hdl/fmc_apb_pkg.sv
hdl/reset_stretch.sv
hdl/fmc_frontend.sv
hdl/apb_requester.sv
hdl/xfer_counters.sv
hdl/fmc_apb_bridge.sv
bench/apb_completer_model.sv
bench/tb_fmc_apb_bridge.sv
